/* design/rv32i_settings.svh */
`ifndef RV32I_SETTINGS_SVH
`define RV32I_SETTINGS_SVH

// Program counter value loaded by reset
`define RV32_RESET_PC 32'h0000_0200

// Architectural integer registers, x0 included
`define RV32_NUM_REGS 32

// Nonzero value makes "jal x0, 0" raise halt
// Handy for directed tests that end in a self-jump
`define RV32_INFINITE_LOOP_HALTS 1

`endif

/* design/rv32i_types_pkg.sv */
package rv32i_types_pkg;

  typedef logic [31:0] word_t;

  // Major opcodes, bits 6:0 of the instruction
  typedef enum logic [6:0] {
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    BRANCH  = 7'b1100011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    IMMED   = 7'b0010011,
    REGREG  = 7'b0110011,
    MISCMEM = 7'b0001111,
    SYSTEM  = 7'b1110011
  } opcode_t;

  // funct3 of OP-IMM
  typedef enum logic [2:0] {
    ADDI  = 3'b000,
    SLLI  = 3'b001,
    SLTI  = 3'b010,
    SLTIU = 3'b011,
    XORI  = 3'b100,
    SRI   = 3'b101,
    ORI   = 3'b110,
    ANDI  = 3'b111
  } imm_funct_t;

  // funct3 of OP
  typedef enum logic [2:0] {
    ADDSUB = 3'b000,
    SLL    = 3'b001,
    SLT    = 3'b010,
    SLTU   = 3'b011,
    XOR    = 3'b100,
    SR     = 3'b101,
    OR     = 3'b110,
    AND    = 3'b111
  } reg_funct_t;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  // Only the privileged group of SYSTEM is decoded
  typedef enum logic [2:0] {
    PRIV = 3'b000
  } system_funct_t;

  typedef enum logic [11:0] {
    ECALL  = 12'h000,
    EBREAK = 12'h001,
    MRET   = 12'h302
  } priv_insn_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU
  } alu_op_t;

  // Operand and write-back selects shared by decoder and top
  typedef enum logic [1:0] {
    A_SEL_RS1,
    A_SEL_PC
  } a_sel_t;

  typedef enum logic [1:0] {
    B_SEL_RS2,
    B_SEL_IMM_I,
    B_SEL_IMM_S,
    B_SEL_IMM_U
  } b_sel_t;

  typedef enum logic [2:0] {
    W_SEL_MEM,
    W_SEL_PC4,
    W_SEL_IMM_U,
    W_SEL_ALU
  } w_sel_t;

  // Instruction formats, MSB first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } rtype_t;

  typedef struct packed {
    logic [11:0] imm11_00;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } itype_t;

  typedef struct packed {
    logic [6:0] imm11_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm04_00;
    opcode_t    opcode;
  } stype_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm04_01;
    logic       imm11;
    opcode_t    opcode;
  } sbtype_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    opcode_t     opcode;
  } utype_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_01;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_t    opcode;
  } ujtype_t;

  // One word, six views
  typedef union packed {
    rtype_t      r;
    itype_t      i;
    stype_t      s;
    sbtype_t     sb;
    utype_t      u;
    ujtype_t     uj;
    logic [31:0] raw;
  } instr_t;

endpackage

/* design/control_unit.sv */
`timescale 1ns/1ps
`include "rv32i_settings.svh"

module control_unit (
  input  rv32i_types_pkg::instr_t  instr_i,
  output logic [4:0]               rs1_o,
  output logic [4:0]               rs2_o,
  output logic [4:0]               rd_o,
  output rv32i_types_pkg::word_t   imm_i_o,
  output rv32i_types_pkg::word_t   imm_s_o,
  output rv32i_types_pkg::word_t   imm_b_o,
  output rv32i_types_pkg::word_t   imm_u_o,
  output rv32i_types_pkg::word_t   imm_j_o,
  output rv32i_types_pkg::a_sel_t  alu_a_sel_o,
  output rv32i_types_pkg::b_sel_t  alu_b_sel_o,
  output rv32i_types_pkg::alu_op_t alu_op_o,
  output rv32i_types_pkg::w_sel_t  w_sel_o,
  output logic                     wen_o,
  output logic                     dren_o,
  output logic                     dwen_o,
  output logic                     branch_o,
  output logic                     jump_o,
  output logic                     j_sel_o,
  output rv32i_types_pkg::branch_t branch_type_o,
  output logic                     illegal_o,
  output logic                     trap_o,
  output logic                     halt_o
);
  import rv32i_types_pkg::*;

  opcode_t    opcode;
  imm_funct_t i_funct;
  reg_funct_t r_funct;
  logic       shift_imm;
  logic       priv_ok;
  priv_insn_t priv_code;

  assign opcode  = instr_i.r.opcode;
  assign i_funct = imm_funct_t'(instr_i.i.funct3);
  assign r_funct = reg_funct_t'(instr_i.r.funct3);

  assign rs1_o = instr_i.r.rs1;
  assign rs2_o = instr_i.r.rs2;
  assign rd_o  = instr_i.r.rd;

  // Immediates, all sign-extended except the shift amount
  assign shift_imm = (opcode == IMMED) && (i_funct == SLLI || i_funct == SRI);

  assign imm_i_o = shift_imm ? {27'b0, instr_i.r.rs2}
                             : {{20{instr_i.i.imm11_00[11]}}, instr_i.i.imm11_00};
  assign imm_s_o = {{20{instr_i.s.imm11_05[6]}}, instr_i.s.imm11_05, instr_i.s.imm04_00};
  assign imm_b_o = {{19{instr_i.sb.imm12}}, instr_i.sb.imm12, instr_i.sb.imm11,
                    instr_i.sb.imm10_05, instr_i.sb.imm04_01, 1'b0};
  assign imm_u_o = {instr_i.u.imm31_12, 12'b0};
  assign imm_j_o = {{11{instr_i.uj.imm20}}, instr_i.uj.imm20, instr_i.uj.imm19_12,
                    instr_i.uj.imm11, instr_i.uj.imm10_01, 1'b0};

  assign branch_type_o = branch_t'(instr_i.sb.funct3);

  assign dwen_o   = (opcode == STORE);
  assign dren_o   = (opcode == LOAD);
  assign branch_o = (opcode == BRANCH);
  assign jump_o   = (opcode == JAL) || (opcode == JALR);
  assign j_sel_o  = (opcode == JAL);

  always_comb begin
    case (opcode)
      AUIPC:   alu_a_sel_o = A_SEL_PC;
      default: alu_a_sel_o = A_SEL_RS1;
    endcase
  end

  always_comb begin
    case (opcode)
      IMMED, LOAD, JALR: alu_b_sel_o = B_SEL_IMM_I;
      STORE:             alu_b_sel_o = B_SEL_IMM_S;
      AUIPC:             alu_b_sel_o = B_SEL_IMM_U;
      default:           alu_b_sel_o = B_SEL_RS2;
    endcase
  end

  always_comb begin
    case (opcode)
      LOAD:      w_sel_o = W_SEL_MEM;
      JAL, JALR: w_sel_o = W_SEL_PC4;
      LUI:       w_sel_o = W_SEL_IMM_U;
      default:   w_sel_o = W_SEL_ALU;
    endcase
  end

  always_comb begin
    case (opcode)
      IMMED, LUI, AUIPC, REGREG, JAL, JALR, LOAD: wen_o = 1'b1;
      default:                                   wen_o = 1'b0;
    endcase
  end

  // ALU operation, first match wins
  always_comb begin
    alu_op_o = ALU_ADD;
    if ((opcode == IMMED && i_funct == SLLI) || (opcode == REGREG && r_funct == SLL)) begin
      alu_op_o = ALU_SLL;
    end else if ((opcode == IMMED && i_funct == SRI) || (opcode == REGREG && r_funct == SR)) begin
      // Bit 30 picks arithmetic over logical
      alu_op_o = instr_i.r.funct7[5] ? ALU_SRA : ALU_SRL;
    end else if (opcode == REGREG && r_funct == ADDSUB) begin
      alu_op_o = instr_i.r.funct7[5] ? ALU_SUB : ALU_ADD;
    end else if ((opcode == IMMED && i_funct == ANDI) || (opcode == REGREG && r_funct == AND)) begin
      alu_op_o = ALU_AND;
    end else if ((opcode == IMMED && i_funct == ORI) || (opcode == REGREG && r_funct == OR)) begin
      alu_op_o = ALU_OR;
    end else if ((opcode == IMMED && i_funct == XORI) || (opcode == REGREG && r_funct == XOR)) begin
      alu_op_o = ALU_XOR;
    end else if ((opcode == IMMED && i_funct == SLTI) || (opcode == REGREG && r_funct == SLT)) begin
      alu_op_o = ALU_SLT;
    end else if ((opcode == IMMED && i_funct == SLTIU) ||
                 (opcode == REGREG && r_funct == SLTU)) begin
      alu_op_o = ALU_SLTU;
    end
  end

  // Privileged SYSTEM group
  assign priv_code = priv_insn_t'(instr_i.i.imm11_00);
  assign priv_ok   = (opcode == SYSTEM) &&
                     (system_funct_t'(instr_i.i.funct3) == PRIV) &&
                     (priv_code == ECALL || priv_code == EBREAK || priv_code == MRET);
  assign trap_o    = priv_ok;

  always_comb begin
    case (opcode)
      // funct7 bit 0 marks the M extension
      REGREG:  illegal_o = instr_i.r.funct7[0];
      SYSTEM:  illegal_o = ~priv_ok;
      LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE, IMMED, MISCMEM: illegal_o = 1'b0;
      default: illegal_o = 1'b1;
    endcase
  end

  // Self-jump used as an end-of-test marker
  generate
    if (`RV32_INFINITE_LOOP_HALTS != 0) begin : g_halt
      assign halt_o = (instr_i.raw == 32'h0000_006f);
    end else begin : g_no_halt
      assign halt_o = 1'b0;
    end
  endgenerate

endmodule

/* design/rv32i_reg_file.sv */
`timescale 1ns/1ps
`include "rv32i_settings.svh"

module rv32i_reg_file (
  input  logic                   CLK,
  input  logic                   rst_n_i,
  input  logic [4:0]             rs1_i,
  input  logic [4:0]             rs2_i,
  input  logic [4:0]             rd_i,
  input  logic                   wen_i,
  input  rv32i_types_pkg::word_t wdata_i,
  output rv32i_types_pkg::word_t rdata1_o,
  output rv32i_types_pkg::word_t rdata2_o
);
  import rv32i_types_pkg::*;

  word_t regs [`RV32_NUM_REGS];

  always_ff @(posedge CLK) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `RV32_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && rd_i != 5'd0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  // x0 is hardwired to zero
  assign rdata1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

/* design/alu.sv */
`timescale 1ns/1ps

module alu (
  input  rv32i_types_pkg::alu_op_t op_i,
  input  rv32i_types_pkg::word_t   a_i,
  input  rv32i_types_pkg::word_t   b_i,
  output rv32i_types_pkg::word_t   result_o
);
  import rv32i_types_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // Only the low five bits count for shifts
  assign shamt       = b_i[4:0];
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = word_t'($signed(a_i) >>> shamt);
      ALU_AND:  result_o = a_i & b_i;
      ALU_OR:   result_o = a_i | b_i;
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SLT:  result_o = {31'b0, lt_signed};
      ALU_SLTU: result_o = {31'b0, lt_unsigned};
      default:  result_o = a_i + b_i;
    endcase
  end

endmodule

/* design/branch_res.sv */
`timescale 1ns/1ps

module branch_res (
  input  rv32i_types_pkg::word_t   rs1_data_i,
  input  rv32i_types_pkg::word_t   rs2_data_i,
  input  rv32i_types_pkg::branch_t branch_type_i,
  output logic                     taken_o
);
  import rv32i_types_pkg::*;

  logic eq;
  logic lt;
  logic ltu;

  assign eq  = (rs1_data_i == rs2_data_i);
  assign lt  = $signed(rs1_data_i) < $signed(rs2_data_i);
  assign ltu = rs1_data_i < rs2_data_i;

  // Condition only, the top level qualifies it with branch
  always_comb begin
    case (branch_type_i)
      BEQ:     taken_o = eq;
      BNE:     taken_o = ~eq;
      BLT:     taken_o = lt;
      BGE:     taken_o = ~lt;
      BLTU:    taken_o = ltu;
      BGEU:    taken_o = ~ltu;
      default: taken_o = 1'b0;
    endcase
  end

endmodule

/* design/rv32i_execute_core.sv */
`timescale 1ns/1ps
`include "rv32i_settings.svh"

module rv32i_execute_core (
  input  logic                   CLK,
  input  logic                   rst_n_i,
  input  logic [31:0]            instr_i,
  input  logic                   instr_valid_i,
  input  rv32i_types_pkg::word_t dmem_rdata_i,
  output rv32i_types_pkg::word_t pc_o,
  output rv32i_types_pkg::word_t dmem_addr_o,
  output rv32i_types_pkg::word_t dmem_wdata_o,
  output logic                   dmem_wen_o,
  output logic                   dmem_ren_o,
  output logic                   retire_we_o,
  output logic [4:0]             retire_rd_o,
  output rv32i_types_pkg::word_t retire_data_o,
  output logic                   illegal_o,
  output logic                   trap_o,
  output logic                   halt_o
);
  import rv32i_types_pkg::*;

  instr_t     instr;
  logic [4:0] rs1, rs2, rd;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  a_sel_t     a_sel;
  b_sel_t     b_sel;
  alu_op_t    alu_op;
  w_sel_t     w_sel;
  logic       wen, dren, dwen, branch, jump, j_sel;
  branch_t    branch_type;
  logic       illegal, trap;

  word_t      pc, pc_next, pc_plus4;
  word_t      rs1_data, rs2_data;
  word_t      alu_a, alu_b, alu_result;
  word_t      wb_data;
  logic       cond_true;
  logic       commit;
  logic       rf_wen;

  assign instr = instr_i;

  control_unit i_control_unit (
    .instr_i       (instr),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .rd_o          (rd),
    .imm_i_o       (imm_i),
    .imm_s_o       (imm_s),
    .imm_b_o       (imm_b),
    .imm_u_o       (imm_u),
    .imm_j_o       (imm_j),
    .alu_a_sel_o   (a_sel),
    .alu_b_sel_o   (b_sel),
    .alu_op_o      (alu_op),
    .w_sel_o       (w_sel),
    .wen_o         (wen),
    .dren_o        (dren),
    .dwen_o        (dwen),
    .branch_o      (branch),
    .jump_o        (jump),
    .j_sel_o       (j_sel),
    .branch_type_o (branch_type),
    .illegal_o     (illegal),
    .trap_o        (trap),
    .halt_o        (halt_o)
  );

  // Nothing retires on a fault or an idle cycle
  assign commit = instr_valid_i & ~illegal & ~trap;
  assign rf_wen = commit & wen;

  rv32i_reg_file i_reg_file (
    .CLK      (CLK),
    .rst_n_i  (rst_n_i),
    .rs1_i    (rs1),
    .rs2_i    (rs2),
    .rd_i     (rd),
    .wen_i    (rf_wen),
    .wdata_i  (wb_data),
    .rdata1_o (rs1_data),
    .rdata2_o (rs2_data)
  );

  assign alu_a = (a_sel == A_SEL_PC) ? pc : rs1_data;

  always_comb begin
    case (b_sel)
      B_SEL_IMM_I: alu_b = imm_i;
      B_SEL_IMM_S: alu_b = imm_s;
      B_SEL_IMM_U: alu_b = imm_u;
      default:     alu_b = rs2_data;
    endcase
  end

  alu i_alu (
    .op_i     (alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .result_o (alu_result)
  );

  branch_res i_branch_res (
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .branch_type_i (branch_type),
    .taken_o       (cond_true)
  );

  assign pc_plus4 = pc + 32'd4;

  // Next pc, JALR clears bit 0 of its target
  always_comb begin
    if (jump && j_sel) begin
      pc_next = pc + imm_j;
    end else if (jump) begin
      pc_next = (rs1_data + imm_i) & ~32'd1;
    end else if (branch && cond_true) begin
      pc_next = pc + imm_b;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n_i) begin
      pc <= `RV32_RESET_PC;
    end else if (commit) begin
      pc <= pc_next;
    end
  end

  always_comb begin
    case (w_sel)
      W_SEL_MEM:   wb_data = dmem_rdata_i;
      W_SEL_PC4:   wb_data = pc_plus4;
      W_SEL_IMM_U: wb_data = imm_u;
      default:     wb_data = alu_result;
    endcase
  end

  // Word-only data memory port
  assign dmem_addr_o  = alu_result;
  assign dmem_wdata_o = rs2_data;
  assign dmem_wen_o   = commit & dwen;
  assign dmem_ren_o   = commit & dren;

  assign retire_we_o   = rf_wen;
  assign retire_rd_o   = rd;
  assign retire_data_o = wb_data;

  assign pc_o      = pc;
  assign illegal_o = illegal;
  assign trap_o    = trap;

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

  // Synchronous reset, released on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* tb/tb_rv32i_core.sv */
`timescale 1ns/1ps
`include "rv32i_settings.svh"

module tb_rv32i_core;

  localparam int CLK_PERIOD_NS = 4;
  localparam int RESET_CYCLES  = 10;
  localparam int ALU_REPS      = 3;
  localparam int MEM_REPS      = 4;
  localparam int JUMP_REPS     = 4;
  // Instructions issued by all tests
  localparam int INSTR_BUDGET  = 41 + 77 * ALU_REPS + 64 + 6 * MEM_REPS + 90 +
                                 6 * JUMP_REPS + 20;
  // Doubled for idle cycles and slack
  localparam int TIMEOUT_NS    = 2 * (RESET_CYCLES + INSTR_BUDGET) * CLK_PERIOD_NS + 100;

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;

  logic        clk;
  logic        rst_n;
  logic [31:0] instr;
  logic        instr_valid;
  logic [31:0] dmem_rdata;
  logic [31:0] pc, dmem_addr, dmem_wdata, retire_data;
  logic        dmem_wen, dmem_ren, retire_we;
  logic [4:0]  retire_rd;
  logic        illegal, trap, halt;

  // Reference state
  logic [31:0] model_regs [32];
  logic [31:0] model_pc;
  logic [31:0] lfsr_state = 32'd77262;

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (RESET_CYCLES)
  ) i_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  rv32i_execute_core i_dut (
    .CLK           (clk),
    .rst_n_i       (rst_n),
    .instr_i       (instr),
    .instr_valid_i (instr_valid),
    .dmem_rdata_i  (dmem_rdata),
    .pc_o          (pc),
    .dmem_addr_o   (dmem_addr),
    .dmem_wdata_o  (dmem_wdata),
    .dmem_wen_o    (dmem_wen),
    .dmem_ren_o    (dmem_ren),
    .retire_we_o   (retire_we),
    .retire_rd_o   (retire_rd),
    .retire_data_o (retire_data),
    .illegal_o     (illegal),
    .trap_o        (trap),
    .halt_o        (halt)
  );

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hD000_0001) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  function automatic logic [4:0] pick_reg();
    logic [4:0] r;
    r = rand_bits(5);
    if (r == 5'd0) begin
      r = 5'd1;
    end
    return r;
  endfunction

  function automatic logic [4:0] pick_other(input logic [4:0] avoid);
    logic [4:0] r;
    r = pick_reg();
    if (r == avoid) begin
      r = (avoid == 5'd31) ? 5'd1 : avoid + 5'd1;
    end
    return r;
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] sext13(input logic [12:0] v);
    return {{19{v[12]}}, v};
  endfunction

  function automatic logic [31:0] sext21(input logic [20:0] v);
    return {{11{v[20]}}, v};
  endfunction

  // Instruction encoders
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  // RV32I integer semantics
  // Alt stands for instruction bit 30
  function automatic logic [31:0] expect_op(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    sa = a;
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'd0, $signed(a) < $signed(b)};
      3'b011:  return {31'd0, a < b};
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) begin
          return sa >>> b[4:0];
        end else begin
          return a >> b[4:0];
        end
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail at %0t: %s expected %08h, actual %08h", $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // One valid instruction with outputs sampled mid-cycle
  task automatic drive(input logic [31:0] word, input logic [31:0] rdata);
    @(posedge clk);
    instr       <= word;
    instr_valid <= 1'b1;
    dmem_rdata  <= rdata;
    @(negedge clk);
    check_eq("pc_o", model_pc, pc);
  endtask

  task automatic idle_cycle(input logic [31:0] word);
    @(posedge clk);
    instr       <= word;
    instr_valid <= 1'b0;
    dmem_rdata  <= rand_bits(32);
    @(negedge clk);
    check_eq("pc_o", model_pc, pc);
    check_eq("retire_we_o", 32'd0, retire_we);
    check_eq("dmem_wen_o", 32'd0, dmem_wen);
    check_eq("dmem_ren_o", 32'd0, dmem_ren);
  endtask

  task automatic retire(input logic [4:0] rd, input logic [31:0] data,
                        input logic [31:0] next_pc, input logic is_load);
    check_eq("retire_we_o", 32'd1, retire_we);
    check_eq("retire_rd_o", rd, retire_rd);
    check_eq("retire_data_o", data, retire_data);
    check_eq("illegal_o", 32'd0, illegal);
    check_eq("trap_o", 32'd0, trap);
    check_eq("dmem_wen_o", 32'd0, dmem_wen);
    check_eq("dmem_ren_o", is_load, dmem_ren);
    if (rd != 5'd0) begin
      model_regs[rd] = data;
    end
    model_pc = next_pc;
  endtask

  // Stores and branches write no register
  task automatic expect_quiet(input logic [31:0] next_pc);
    check_eq("retire_we_o", 32'd0, retire_we);
    check_eq("illegal_o", 32'd0, illegal);
    check_eq("trap_o", 32'd0, trap);
    check_eq("dmem_ren_o", 32'd0, dmem_ren);
    model_pc = next_pc;
  endtask

  task automatic expect_fault(input logic exp_illegal, input logic exp_trap);
    check_eq("illegal_o", exp_illegal, illegal);
    check_eq("trap_o", exp_trap, trap);
    check_eq("retire_we_o", 32'd0, retire_we);
    check_eq("dmem_wen_o", 32'd0, dmem_wen);
    check_eq("dmem_ren_o", 32'd0, dmem_ren);
  endtask

  // LUI then ADDI with the upper part rounded for the signed low half
  task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
    logic [19:0] upper;
    upper = value[31:12] + {19'd0, value[11]};
    drive(enc_u(upper, rd, OP_LUI), 32'd0);
    retire(rd, {upper, 12'd0}, model_pc + 32'd4, 1'b0);
    drive(enc_i(value[11:0], rd, 3'b000, rd, OP_IMM), 32'd0);
    retire(rd, value, model_pc + 32'd4, 1'b0);
  endtask

  task automatic alu_rr(input logic [2:0] f3, input logic alt, input logic [31:0] va,
                        input logic [31:0] vb);
    logic [4:0] ra;
    logic [4:0] rb;
    logic [4:0] rd;
    ra = pick_reg();
    rb = pick_other(ra);
    rd = pick_reg();
    load_reg(ra, va);
    load_reg(rb, vb);
    drive(enc_r({1'b0, alt, 5'd0}, rb, ra, f3, rd, OP_REG), 32'd0);
    retire(rd, expect_op(f3, alt, va, vb), model_pc + 32'd4, 1'b0);
  endtask

  task automatic alu_ri(input logic [2:0] f3, input logic alt, input logic [31:0] va,
                        input logic [11:0] imm);
    logic [4:0]  ra;
    logic [4:0]  rd;
    logic [11:0] field;
    logic [31:0] b;
    ra = pick_reg();
    rd = pick_reg();
    if (f3 == 3'b001 || f3 == 3'b101) begin
      // Shift amount plus the arithmetic bit
      field = {1'b0, alt, 5'd0, imm[4:0]};
      b     = {27'd0, imm[4:0]};
    end else begin
      field = imm;
      b     = sext12(imm);
    end
    load_reg(ra, va);
    drive(enc_i(field, ra, f3, rd, OP_IMM), 32'd0);
    retire(rd, expect_op(f3, alt && f3 == 3'b101, va, b), model_pc + 32'd4, 1'b0);
  endtask

  task automatic slt_pair(input logic [31:0] a, input logic [31:0] b);
    alu_rr(3'b010, 1'b0, a, b);
    alu_rr(3'b011, 1'b0, a, b);
    alu_ri(3'b010, 1'b0, a, b[11:0]);
    alu_ri(3'b011, 1'b0, a, b[11:0]);
  endtask

  task automatic test_reset_and_x0();
    logic [11:0] imm;
    check_eq("pc_o", `RV32_RESET_PC, pc);
    for (int r = 1; r < 32; r++) begin
      drive(enc_r(7'd0, 5'd0, r[4:0], 3'b000, r[4:0], OP_REG), 32'd0);
      retire(r[4:0], 32'd0, model_pc + 32'd4, 1'b0);
    end
    for (int r = 1; r < 9; r++) begin
      imm = rand_bits(12);
      drive(enc_i(imm, 5'd0, 3'b000, r[4:0], OP_IMM), 32'd0);
      retire(r[4:0], sext12(imm), model_pc + 32'd4, 1'b0);
    end
    imm = rand_bits(12) | 12'd1;
    drive(enc_i(imm, 5'd0, 3'b000, 5'd0, OP_IMM), 32'd0);
    retire(5'd0, sext12(imm), model_pc + 32'd4, 1'b0);
    drive(enc_r(7'd0, 5'd0, 5'd0, 3'b000, 5'd9, OP_REG), 32'd0);
    retire(5'd9, 32'd0, model_pc + 32'd4, 1'b0);
  endtask

  task automatic test_alu();
    for (int rep = 0; rep < ALU_REPS; rep++) begin
      for (int f = 0; f < 8; f++) begin
        alu_rr(f[2:0], 1'b0, rand_bits(32), rand_bits(32));
        alu_ri(f[2:0], 1'b0, rand_bits(32), rand_bits(12));
      end
      alu_rr(3'b000, 1'b1, rand_bits(32), rand_bits(32));
      alu_rr(3'b101, 1'b1, rand_bits(32), rand_bits(32));
      alu_ri(3'b101, 1'b1, rand_bits(32), rand_bits(12));
    end
    // Compares across the sign boundary
    slt_pair(32'h8000_0000, 32'h7fff_ffff);
    slt_pair(32'h7fff_ffff, 32'h8000_0000);
    slt_pair(32'hffff_ffff, 32'h0000_0000);
    slt_pair(32'h0000_0000, 32'hffff_ffff);
  endtask

  task automatic test_mem();
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [4:0]  rd;
    logic [31:0] base;
    logic [31:0] data;
    logic [11:0] imm;
    for (int rep = 0; rep < MEM_REPS; rep++) begin
      ra   = pick_reg();
      rb   = pick_other(ra);
      rd   = pick_reg();
      base = rand_bits(32);
      data = rand_bits(32);
      imm  = rand_bits(12);
      load_reg(ra, base);
      load_reg(rb, data);
      drive(enc_s(imm, rb, ra), rand_bits(32));
      check_eq("dmem_wen_o", 32'd1, dmem_wen);
      check_eq("dmem_addr_o", base + sext12(imm), dmem_addr);
      check_eq("dmem_wdata_o", data, dmem_wdata);
      expect_quiet(model_pc + 32'd4);
      imm  = rand_bits(12);
      data = rand_bits(32);
      drive(enc_i(imm, ra, 3'b010, rd, OP_LOAD), data);
      check_eq("dmem_addr_o", base + sext12(imm), dmem_addr);
      retire(rd, data, model_pc + 32'd4, 1'b1);
    end
  endtask

  task automatic branch_once(input logic [2:0] f3, input logic [31:0] a,
                             input logic [31:0] b);
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [12:0] imm;
    ra  = pick_reg();
    rb  = pick_other(ra);
    imm = {rand_bits(12), 1'b0};
    load_reg(ra, a);
    load_reg(rb, b);
    drive(enc_b(imm, rb, ra, f3), 32'd0);
    check_eq("dmem_wen_o", 32'd0, dmem_wen);
    expect_quiet(branch_cond(f3, a, b) ? model_pc + sext13(imm) : model_pc + 32'd4);
  endtask

  // Equal, negative first and positive first give each condition both outcomes
  task automatic test_branches();
    logic [31:0] pos;
    logic [31:0] neg;
    for (int f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        pos = rand_bits(32) & 32'h7fff_ffff;
        neg = rand_bits(32) | 32'h8000_0000;
        branch_once(f[2:0], pos, pos);
        branch_once(f[2:0], neg, pos);
        branch_once(f[2:0], pos, neg);
      end
    end
  endtask

  task automatic test_jumps_and_upper();
    logic [4:0]  ra;
    logic [4:0]  rd;
    logic [20:0] jimm;
    logic [11:0] imm;
    logic [19:0] u;
    logic [31:0] base;
    for (int rep = 0; rep < JUMP_REPS; rep++) begin
      rd   = pick_reg();
      jimm = {rand_bits(20), 1'b0};
      drive(enc_j(jimm, rd), 32'd0);
      check_eq("halt_o", 32'd0, halt);
      retire(rd, model_pc + 32'd4, model_pc + sext21(jimm), 1'b0);
      ra   = pick_reg();
      rd   = pick_reg();
      base = rand_bits(32);
      imm  = rand_bits(12);
      load_reg(ra, base);
      drive(enc_i(imm, ra, 3'b000, rd, OP_JALR), 32'd0);
      retire(rd, model_pc + 32'd4, (base + sext12(imm)) & ~32'd1, 1'b0);
      u = rand_bits(20);
      drive(enc_u(u, rd, OP_LUI), 32'd0);
      retire(rd, {u, 12'd0}, model_pc + 32'd4, 1'b0);
      drive(enc_u(u, rd, OP_AUIPC), 32'd0);
      retire(rd, model_pc + {u, 12'd0}, model_pc + 32'd4, 1'b0);
    end
  endtask

  task automatic test_faults_and_idle();
    logic [4:0]  rd;
    logic [4:0]  rd2;
    logic [31:0] keep;
    rd   = pick_reg();
    keep = model_regs[rd];
    // MUL belongs to the M extension
    drive(enc_r(7'b0000001, pick_reg(), pick_reg(), 3'b000, rd, OP_REG), 32'd0);
    expect_fault(1'b1, 1'b0);
    drive(enc_i(rand_bits(12), pick_reg(), 3'b000, rd, 7'b0001011), 32'd0);
    expect_fault(1'b1, 1'b0);
    drive(32'h0000_0073, 32'd0);  // ECALL
    expect_fault(1'b0, 1'b1);
    drive(32'h0010_0073, 32'd0);  // EBREAK
    expect_fault(1'b0, 1'b1);
    drive(32'h3020_0073, 32'd0);  // MRET
    expect_fault(1'b0, 1'b1);
    drive(32'h1050_0073, 32'd0);  // WFI is not decoded
    expect_fault(1'b1, 1'b0);
    rd2 = pick_reg();
    drive(enc_r(7'd0, 5'd0, rd, 3'b000, rd2, OP_REG), 32'd0);
    retire(rd2, keep, model_pc + 32'd4, 1'b0);
    // Self-jump stays put and raises halt
    drive(32'h0000_006f, 32'd0);
    check_eq("halt_o", 32'd1, halt);
    retire(5'd0, model_pc + 32'd4, model_pc, 1'b0);
    drive(enc_j(21'd8, 5'd0), 32'd0);
    check_eq("halt_o", 32'd0, halt);
    retire(5'd0, model_pc + 32'd4, model_pc + 32'd8, 1'b0);
    rd   = pick_reg();
    keep = model_regs[rd];
    idle_cycle(enc_i(12'h5a5, 5'd0, 3'b000, rd, OP_IMM));
    idle_cycle(enc_s(12'h010, rd, 5'd0));
    idle_cycle(enc_i(12'h020, 5'd0, 3'b010, rd, OP_LOAD));
    rd2 = pick_reg();
    drive(enc_r(7'd0, 5'd0, rd, 3'b000, rd2, OP_REG), 32'd0);
    retire(rd2, keep, model_pc + 32'd4, 1'b0);
    idle_cycle(32'd0);
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns, the tests did not reach their end", TIMEOUT_NS);
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    instr       = 32'd0;
    instr_valid = 1'b0;
    dmem_rdata  = 32'd0;
    model_pc    = `RV32_RESET_PC;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = 32'd0;
    end
    wait (rst_n === 1'b1);
    @(negedge clk);
    test_reset_and_x0();
    test_alu();
    test_mem();
    test_branches();
    test_jumps_and_upper();
    test_faults_and_idle();
    $display("Simulation passed");
    $finish;
  end

endmodule

/* src.f */
+incdir+design
design/rv32i_types_pkg.sv
design/control_unit.sv
design/rv32i_reg_file.sv
design/alu.sv
design/branch_res.sv
design/rv32i_execute_core.sv
tb/tb_clock_gen.sv
tb/tb_rv32i_core.sv
